// File: all.f
+incdir+source
source/mem_pkg.sv
source/fifo_queue.sv
source/mem_arbiter.sv
source/mem_store.sv
source/mem_subsystem.sv
bench/mem_subsystem_tb.sv

// File: run.sh
#!/bin/sh
# Build the testbench with Verilator and run it; a $fatal gives a failing exit status.

cd "$(dirname "$0")" &&
verilator --binary --timing -f all.f --top-module mem_subsystem_tb \
  -o sim_mem_subsystem &&
./obj_dir/sim_mem_subsystem ||
{ echo "Simulation did not pass"; exit 1; }

// File: bench/mem_subsystem_tb.sv
// Testbench for the shared memory subsystem.
// Random masters with an LCG, a reference memory model and per-master expected queues.

`timescale 1ns/1ps

`include "mem_cfg.svh"

module mem_subsystem_tb;

  localparam int CLK_PERIOD     = 100;
  localparam int DRIVE_DELAY    = 1;
  localparam int REQS_PER_MSTR  = 150;
  localparam int TOTAL_REQS     = REQS_PER_MSTR * `MEM_MASTERS;
  localparam int CYCLES_PER_REQ = 40;
  localparam int WATCHDOG_NS    = TOTAL_REQS * CYCLES_PER_REQ * CLK_PERIOD;
  localparam int DRAIN_CYCLES   = 200;
  localparam int WORDS          = 1 << `MEM_ADDR_WIDTH;

  logic                      clk = 1'b0;
  logic                      rst;
  logic [`MEM_MASTERS-1:0]   req_valid;
  logic [`MEM_MASTERS-1:0]   req_ready;
  mem_pkg::mem_req_t         req [`MEM_MASTERS];
  logic [`MEM_MASTERS-1:0]   resp_valid;
  logic [`MEM_MASTERS-1:0]   resp_ready;
  mem_pkg::mem_resp_t        resp [`MEM_MASTERS];

  // Reference model state.
  logic [`MEM_DATA_WIDTH-1:0] model_mem [WORDS];
  logic [`MEM_DATA_WIDTH-1:0] exp_q [`MEM_MASTERS][$];
  logic [`MEM_DATA_WIDTH-1:0] held_data [`MEM_MASTERS];
  logic                       held [`MEM_MASTERS];

  // Master state.
  int   issued [`MEM_MASTERS];
  int   idle_cnt [`MEM_MASTERS];
  logic active [`MEM_MASTERS];
  logic drain;

  int unsigned rng_state = 90172;

  mem_subsystem u_mem_subsystem (
    .clk        (clk),
    .rst        (rst),
    .req_valid  (req_valid),
    .req_ready  (req_ready),
    .req        (req),
    .resp_valid (resp_valid),
    .resp_ready (resp_ready),
    .resp       (resp)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  // Upper bits of the LCG state have the better period.
  function automatic logic [15:0] next_rand();
    rng_state = rng_state * 32'd1103515245 + 32'd12345;
    return rng_state[30:15];
  endfunction

  task automatic report_failure(input string msg);
    $display("CHECK FAILED at %0t: %s", $time, msg);
    $display("Result: FAILED");
    $fatal(1, "stopping at first error");
  endtask

  task automatic check_idle_outputs(input string phase);
    assert (req_ready == '0 && resp_valid == '0)
      else report_failure($sformatf("handshake outputs active %s", phase));
  endtask

  function automatic logic all_issued();
    logic done;
    done = 1'b1;
    for (int m = 0; m < `MEM_MASTERS; m++) begin
      if (issued[m] != REQS_PER_MSTR || active[m]) begin
        done = 1'b0;
      end
    end
    return done;
  endfunction

  // New requests start after the idle gap and stay put until accepted.
  task automatic drive_masters();
    for (int m = 0; m < `MEM_MASTERS; m++) begin
      if (!active[m] && issued[m] < REQS_PER_MSTR) begin
        if (idle_cnt[m] == 0) begin
          active[m]       = 1'b1;
          req[m].write    = (next_rand() % 2) == 1;
          req[m].addr     = `MEM_ADDR_WIDTH'(next_rand() % 8);
          req[m].wdata    = {next_rand(), next_rand()};
        end else begin
          idle_cnt[m]--;
        end
      end
      req_valid[m]  = active[m];
      resp_ready[m] = drain ? 1'b1 : ((next_rand() % 10) < 6);
    end
  endtask

  task automatic sample_cycle();
    logic [`MEM_DATA_WIDTH-1:0] expected;
    for (int m = 0; m < `MEM_MASTERS; m++) begin
      if (held[m]) begin
        assert (resp_valid[m] && resp[m].rdata == held_data[m])
          else report_failure($sformatf("master %0d stalled response dropped or changed", m));
      end
      if (resp_valid[m]) begin
        assert (exp_q[m].size() > 0)
          else report_failure($sformatf("master %0d response with nothing outstanding", m));
        if (resp_ready[m]) begin
          expected = exp_q[m].pop_front();
          assert (resp[m].rdata == expected)
            else report_failure($sformatf("master %0d rdata %h expected %h",
                                          m, resp[m].rdata, expected));
          held[m] = 1'b0;
        end else begin
          held[m]      = 1'b1;
          held_data[m] = resp[m].rdata;
        end
      end
    end
    for (int m = 0; m < `MEM_MASTERS; m++) begin
      if (req_valid[m] && req_ready[m]) begin
        for (int j = 0; j < m; j++) begin
          assert (!req_valid[j])
            else report_failure($sformatf("master %0d accepted over master %0d", m, j));
        end
        // Old word goes back to the master, then the write lands.
        exp_q[m].push_back(model_mem[req[m].addr]);
        if (req[m].write) begin
          model_mem[req[m].addr] = req[m].wdata;
        end
        active[m]   = 1'b0;
        issued[m]++;
        idle_cnt[m] = int'(next_rand() % 4);
      end
    end
  endtask

  task automatic run_cycle();
    @(posedge clk);
    #DRIVE_DELAY;
    drive_masters();
    @(negedge clk);
    sample_cycle();
  endtask

  initial begin
    #(WATCHDOG_NS);
    $display("Simulation hung: watchdog limit of %0d ns reached", WATCHDOG_NS);
    $display("Result: FAILED");
    $fatal(1, "watchdog timeout");
  end

  initial begin
    logic queues_empty;
    rst        = 1'b1;
    req_valid  = '0;
    resp_ready = '0;
    drain      = 1'b0;
    for (int m = 0; m < `MEM_MASTERS; m++) begin
      req[m]       = '0;
      held[m]      = 1'b0;
      held_data[m] = '0;
      issued[m]    = 0;
      active[m]    = 1'b0;
      idle_cnt[m]  = 0;
    end
    for (int a = 0; a < WORDS; a++) begin
      model_mem[a] = '0;
    end

    // Each master has a request pending through reset.
    drive_masters();

    repeat (2) begin
      @(posedge clk);
      #DRIVE_DELAY;
      check_idle_outputs("during reset");
    end
    rst = 1'b0;
    @(negedge clk);
    check_idle_outputs("after reset");

    while (!all_issued()) begin
      run_cycle();
    end

    // Let every outstanding response drain.
    drain = 1'b1;
    repeat (DRAIN_CYCLES) begin
      run_cycle();
    end

    queues_empty = 1'b1;
    for (int m = 0; m < `MEM_MASTERS; m++) begin
      if (exp_q[m].size() != 0) begin
        $display("Master %0d still waits for %0d responses", m, exp_q[m].size());
        queues_empty = 1'b0;
      end
    end
    assert (queues_empty) begin
      $display("Result: PASSED");
      $finish;
    end else begin
      report_failure("responses missing after drain");
    end
  end

endmodule

// File: source/mem_subsystem.sv
// Shared memory subsystem top.
// Masters reach one memory through the fixed-priority arbiter.

`timescale 1ns/1ps

`include "mem_cfg.svh"

module mem_subsystem (
  input  logic                     clk,
  input  logic                     rst,

  input  logic [`MEM_MASTERS-1:0]  req_valid,
  output logic [`MEM_MASTERS-1:0]  req_ready,
  input  mem_pkg::mem_req_t        req [`MEM_MASTERS],

  output logic [`MEM_MASTERS-1:0]  resp_valid,
  input  logic [`MEM_MASTERS-1:0]  resp_ready,
  output mem_pkg::mem_resp_t       resp [`MEM_MASTERS]
);

  // Arbiter to memory channels.
  logic               mem_req_valid;
  logic               mem_req_ready;
  mem_pkg::mem_req_t  mem_req;
  logic               mem_resp_valid;
  logic               mem_resp_ready;
  mem_pkg::mem_resp_t mem_resp;

  mem_arbiter #(
    .CNT (`MEM_MASTERS)
  ) u_mem_arbiter (
    .clk            (clk),
    .rst            (rst),
    .req_valid      (req_valid),
    .req_ready      (req_ready),
    .req            (req),
    .resp_valid     (resp_valid),
    .resp_ready     (resp_ready),
    .resp           (resp),
    .mem_req_valid  (mem_req_valid),
    .mem_req_ready  (mem_req_ready),
    .mem_req        (mem_req),
    .mem_resp_valid (mem_resp_valid),
    .mem_resp_ready (mem_resp_ready),
    .mem_resp       (mem_resp)
  );

  mem_store u_mem_store (
    .clk        (clk),
    .rst        (rst),
    .req_valid  (mem_req_valid),
    .req_ready  (mem_req_ready),
    .req        (mem_req),
    .resp_valid (mem_resp_valid),
    .resp_ready (mem_resp_ready),
    .resp       (mem_resp)
  );

endmodule

// File: source/mem_store.sv
// On-chip word memory.
// Every request returns the old word; writes then store wdata.
// Contents are swept to zero after reset before requests are taken.

`timescale 1ns/1ps

`include "mem_cfg.svh"

module mem_store (
  input  logic               clk,
  input  logic               rst,

  input  logic               req_valid,
  output logic               req_ready,
  input  mem_pkg::mem_req_t  req,

  output logic               resp_valid,
  input  logic               resp_ready,
  output mem_pkg::mem_resp_t resp
);

  localparam int WORDS = 1 << `MEM_ADDR_WIDTH;

  logic [`MEM_DATA_WIDTH-1:0] words [WORDS];

  logic                       clearing;
  logic [`MEM_ADDR_WIDTH-1:0] clear_addr;

  logic                       accept;
  logic                       resp_enq_ready;
  mem_pkg::mem_resp_t         old_word;

  // Response FIFO captures the old word at acceptance.
  fifo_queue #(
    .payload_t   (mem_pkg::mem_resp_t),
    .DEPTH       (`MEM_RESP_DEPTH),
    .FALLTHROUGH (1'b0)
  ) u_resp_fifo (
    .clk       (clk),
    .rst       (rst),
    .enq_valid (accept),
    .enq_ready (resp_enq_ready),
    .enq_data  (old_word),
    .deq_valid (resp_valid),
    .deq_ready (resp_ready),
    .deq_data  (resp)
  );

  assign req_ready      = resp_enq_ready && !clearing;
  assign accept         = req_valid && req_ready;
  assign old_word.rdata = words[req.addr];

  // Clear sweep, one word per cycle.
  always_ff @(posedge clk) begin
    if (rst) begin
      clearing   <= 1'b1;
      clear_addr <= '0;
    end else if (clearing) begin
      clear_addr <= clear_addr + 1'b1;
      if (clear_addr == '1) begin
        clearing <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (clearing) begin
      words[clear_addr] <= '0;
    end else if (accept && req.write) begin
      words[req.addr] <= req.wdata;
    end
  end

endmodule

// File: source/mem_arbiter.sv
// Fixed-priority memory arbiter.
// Lowest master index wins; responses return in grant order.

`timescale 1ns/1ps

`include "mem_cfg.svh"

module mem_arbiter #(
  parameter int CNT = 2
) (
  input  logic               clk,
  input  logic               rst,

  input  logic [CNT-1:0]     req_valid,
  output logic [CNT-1:0]     req_ready,
  input  mem_pkg::mem_req_t  req [CNT],

  output logic [CNT-1:0]     resp_valid,
  input  logic [CNT-1:0]     resp_ready,
  output mem_pkg::mem_resp_t resp [CNT],

  output logic               mem_req_valid,
  input  logic               mem_req_ready,
  output mem_pkg::mem_req_t  mem_req,

  input  logic               mem_resp_valid,
  output logic               mem_resp_ready,
  input  mem_pkg::mem_resp_t mem_resp
);

  mem_pkg::master_idx_t sel;
  logic                 has_req;
  logic                 grant;

  logic                 order_enq_valid;
  logic                 order_enq_ready;
  logic                 order_deq_valid;
  logic                 order_deq_ready;
  mem_pkg::master_idx_t head;
  logic                 head_ready;

  // Order queue holds the index of every granted master.
  // Its head owns the next memory response.
  fifo_queue #(
    .payload_t   (mem_pkg::master_idx_t),
    .DEPTH       (`MEM_ORDER_DEPTH),
    .FALLTHROUGH (1'b1)
  ) u_order_queue (
    .clk       (clk),
    .rst       (rst),
    .enq_valid (order_enq_valid),
    .enq_ready (order_enq_ready),
    .enq_data  (sel),
    .deq_valid (order_deq_valid),
    .deq_ready (order_deq_ready),
    .deq_data  (head)
  );

  // Walk from the top so the lowest valid index is the one left in sel.
  always_comb begin
    has_req = 1'b0;
    sel     = '0;
    for (int i = CNT - 1; i >= 0; i--) begin
      if (req_valid[i]) begin
        has_req = 1'b1;
        sel     = mem_pkg::master_idx_t'(i);
      end
    end
  end

  assign mem_req         = req[sel];
  assign mem_req_valid   = has_req && order_enq_ready && !rst;
  assign order_enq_valid = has_req && mem_req_ready && !rst;
  assign grant           = mem_req_valid && mem_req_ready;

  for (genvar i = 0; i < CNT; i++) begin : g_req_ready
    assign req_ready[i] = grant && (sel == mem_pkg::master_idx_t'(i));
  end

  // Ready of the master owning the response at the head.
  always_comb begin
    head_ready = 1'b0;
    for (int i = 0; i < CNT; i++) begin
      if (head == mem_pkg::master_idx_t'(i)) begin
        head_ready = resp_ready[i];
      end
    end
  end

  for (genvar i = 0; i < CNT; i++) begin : g_resp
    assign resp_valid[i] = mem_resp_valid && order_deq_valid && !rst &&
                           (head == mem_pkg::master_idx_t'(i));
    assign resp[i]       = mem_resp;
  end

  assign mem_resp_ready  = order_deq_valid && head_ready && !rst;
  assign order_deq_ready = mem_resp_valid && head_ready;

endmodule

// File: source/fifo_queue.sv
// Generic valid/ready FIFO.
// Circular buffer with an optional fall-through path when empty.

`timescale 1ns/1ps

module fifo_queue #(
  parameter type payload_t = logic [7:0],
  parameter int DEPTH = 4,
  parameter bit FALLTHROUGH = 1'b0
) (
  input  logic     clk,
  input  logic     rst,

  input  logic     enq_valid,
  output logic     enq_ready,
  input  payload_t enq_data,

  output logic     deq_valid,
  input  logic     deq_ready,
  output payload_t deq_data
);

  localparam int PTR_WIDTH = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_WIDTH = $clog2(DEPTH + 1);

  payload_t entries [DEPTH];

  logic [PTR_WIDTH-1:0] rd_ptr;
  logic [PTR_WIDTH-1:0] wr_ptr;
  logic [CNT_WIDTH-1:0] count;

  logic empty;
  logic full;
  logic bypass;
  logic do_write;
  logic do_read;

  assign empty = (count == '0);
  assign full  = (count == CNT_WIDTH'(DEPTH));

  // Entry arriving into an empty queue shows up at the output directly.
  assign bypass = FALLTHROUGH && empty && enq_valid;

  assign enq_ready = !full;
  assign deq_valid = !empty || bypass;
  assign deq_data  = (FALLTHROUGH && empty) ? enq_data : entries[rd_ptr];

  // A bypassed entry taken in the same cycle never lands in storage.
  assign do_write = enq_valid && enq_ready && !(bypass && deq_ready);
  assign do_read  = deq_ready && !empty;

  always_ff @(posedge clk) begin
    if (do_write) begin
      entries[wr_ptr] <= enq_data;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      rd_ptr <= '0;
      wr_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_write) begin
        wr_ptr <= (wr_ptr == PTR_WIDTH'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (do_read) begin
        rd_ptr <= (rd_ptr == PTR_WIDTH'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({do_write, do_read})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

// File: source/mem_pkg.sv
// Shared memory subsystem types.
// Request and response payloads plus the master index type.

`include "mem_cfg.svh"

package mem_pkg;

  // Index width for the configured master count.
  // A single master still needs one bit to index the ports.
  localparam int MASTER_IDX_WIDTH =
    (`MEM_MASTERS > 1) ? $clog2(`MEM_MASTERS) : 1;

  // Index of a master port.
  // Carried through the arbiter order queue.
  typedef logic [MASTER_IDX_WIDTH-1:0] master_idx_t;

  // Memory request.
  // A write stores wdata, a read ignores it.
  typedef struct packed {
    logic                       write;
    logic [`MEM_ADDR_WIDTH-1:0] addr;
    logic [`MEM_DATA_WIDTH-1:0] wdata;
  } mem_req_t;

  // Memory response.
  // Always the word held before the request was applied.
  typedef struct packed {
    logic [`MEM_DATA_WIDTH-1:0] rdata;
  } mem_resp_t;

endpackage

// File: source/mem_cfg.svh
// Shared memory subsystem sizes.
// Master count, memory geometry and queue depths used across the design.

`ifndef MEM_CFG_SVH
`define MEM_CFG_SVH

// Number of master ports on the arbiter.
`define MEM_MASTERS 3

// Word address width, 64 words.
`define MEM_ADDR_WIDTH 6

// Width of one stored word.
`define MEM_DATA_WIDTH 32

// Arbiter order queue entries.
// This bounds the number of outstanding responses.
`define MEM_ORDER_DEPTH 4

// Memory response FIFO entries.
`define MEM_RESP_DEPTH 2

`endif
